/* sources.f */
+incdir+bench
hw/rob_pkg.sv
hw/modn_counter.sv
hw/rob_entry_store.sv
hw/rob_clear_tracker.sv
hw/rob_commit_select.sv
hw/rob_top.sv
bench/tb_rob.sv

/* Bender.yml */
package:
  name: rob

sources:
  # Design, package first
  - hw/rob_pkg.sv
  - hw/modn_counter.sv
  - hw/rob_entry_store.sv
  - hw/rob_clear_tracker.sv
  - hw/rob_commit_select.sv
  - hw/rob_top.sv
  # Testbench
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_rob.sv

/* bench/tb_rob_tasks.svh */
/* Drive, compare and directed test tasks of the ROB testbench.
   Included inside the testbench top, uses its signals and model. */

// --------------------------------------------------------------------
// Helpers
// --------------------------------------------------------------------
task automatic stop_on_error(input string msg);
  $display("%s", msg);
  $display("TB FAILED");
  $fatal(1, "Simulation stopped at first error");
endtask

// 32-bit xorshift generator
function automatic xlen_t xorshift32();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

function automatic rob_entry_t make_entry(input logic rd_upd, input reg_idx_t rd,
                                          input logic order_crit, input logic mem_crit);
  rob_entry_t e;
  e             = '0;
  e.rd_upd      = rd_upd;
  e.rd_idx      = rd;
  e.except_code = E_NONE;
  e.order_crit  = order_crit;
  e.mem_crit    = mem_crit;
  return e;
endfunction

function automatic rob_fwd_t expected_fwd(input logic v, input logic r, input xlen_t val);
  rob_fwd_t f;
  f.valid = v;
  f.ready = r;
  f.value = val;
  return f;
endfunction

// Typed compares
task automatic check_entry(input rob_entry_t got, input rob_entry_t exp, input string what);
  if (got !== exp) begin
    stop_on_error($sformatf("[ERROR] %0t: %s got %h, expected %h", $time, what, got, exp));
  end
endtask

task automatic check_idx(input rob_idx_t got, input rob_idx_t exp, input string what);
  if (got !== exp) begin
    stop_on_error($sformatf("[ERROR] %0t: %s got %0d, expected %0d", $time, what, got, exp));
  end
endtask

task automatic check_fwd(input rob_fwd_t got, input rob_fwd_t exp, input string what);
  if (got !== exp) begin
    stop_on_error($sformatf("[ERROR] %0t: %s got %h, expected %h", $time, what, got, exp));
  end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    stop_on_error($sformatf("[ERROR] %0t: %s got %b, expected %b", $time, what, got, exp));
  end
endtask

// --------------------------------------------------------------------
// Drive tasks
// --------------------------------------------------------------------
// Pushes one entry into the slot the model expects and returns that slot
task automatic issue_entry(input rob_entry_t e, output rob_idx_t idx);
  int n;
  n = 0;
  @(posedge clk);
  issue_valid <= 1'b1;
  issue_data  <= e;
  @(negedge clk);
  while (!issue_ready) begin
    if (n == TIMEOUT_CYC) stop_on_error("Timed out waiting for the issue port to accept");
    n++;
    @(negedge clk);
  end
  check_idx(issue_tail, exp_tail, "issue_tail_idx_o");
  idx          = exp_tail;
  exp_mem[idx] = e;
  exp_tail     = exp_tail + 1'b1;
  @(posedge clk);
  issue_valid <= 1'b0;
endtask

// One-cycle CDB pulse
task automatic post_result(input rob_idx_t idx, input xlen_t val, input logic exc,
                           input except_code_t code);
  cdb_data_t d;
  d.rob_idx       = idx;
  d.res_value     = val;
  d.except_raised = exc;
  d.except_code   = code;
  @(posedge clk);
  cdb_valid <= 1'b1;
  cdb_data  <= d;
  exp_mem[idx].res_ready     = 1'b1;
  exp_mem[idx].res_value     = val;
  exp_mem[idx].except_raised = exc;
  exp_mem[idx].except_code   = code;
  @(posedge clk);
  cdb_valid <= 1'b0;
endtask

// Waits for the next offer, checks it and accepts it for one edge
task automatic commit_next();
  rob_idx_t idx;
  int       n;
  idx = exp_q.pop_front();
  n   = 0;
  @(negedge clk);
  while (!comm_valid) begin
    if (n == TIMEOUT_CYC) stop_on_error("Timed out waiting for a commit on the commit port");
    n++;
    @(negedge clk);
  end
  check_idx(comm_idx, idx, "comm_idx_o");
  check_entry(comm_data, exp_mem[idx], "comm_data_o");
  @(posedge clk);
  comm_ready <= 1'b1;
  @(posedge clk);
  comm_ready <= 1'b0;
endtask

task automatic drain_commits();
  while (exp_q.size() > 0) begin
    commit_next();
  end
endtask

// --------------------------------------------------------------------
// Directed tests
// --------------------------------------------------------------------
task automatic in_order_flow();
  rob_entry_t e;
  rob_idx_t   idx [5];
  int         i;
  @(negedge clk);
  check_bit(issue_ready, 1'b1, "issue_ready_o after reset");
  check_bit(comm_valid, 1'b0, "comm_valid_o after reset");
  check_bit(sb_clear, 1'b0, "sb_mem_clear_o after reset");
  check_idx(issue_tail, '0, "issue_tail_idx_o after reset");
  for (i = 0; i < 5; i++) begin
    e = make_entry(1'b1, reg_idx_t'(i + 1), 1'b1, 1'b0);
    issue_entry(e, idx[i]);
    exp_q.push_back(idx[i]);
  end
  // Results arrive in reverse and nothing commits before the head
  for (i = 4; i >= 0; i--) begin
    post_result(idx[i], xorshift32(), 1'b0, E_NONE);
    if (i > 0) begin
      @(negedge clk);
      check_bit(comm_valid, 1'b0, "comm_valid_o before head result");
    end
  end
  drain_commits();
endtask

task automatic lookahead_commit();
  rob_entry_t a, b;
  rob_idx_t   ia, ib;
  int         i;
  // Independent B passes the stalled head
  a = make_entry(1'b1, 5'd3, 1'b0, 1'b0);
  b = make_entry(1'b1, 5'd7, 1'b0, 1'b0);
  issue_entry(a, ia);
  issue_entry(b, ib);
  post_result(ib, xorshift32(), 1'b0, E_NONE);
  exp_q.push_back(rob_idx_t'(ia + 1));
  drain_commits();
  post_result(ia, xorshift32(), 1'b0, E_NONE);
  exp_q.push_back(ia);
  drain_commits();
  // B with the same rd has to wait for A
  a = make_entry(1'b1, 5'd9, 1'b0, 1'b0);
  b = make_entry(1'b1, 5'd9, 1'b0, 1'b0);
  issue_entry(a, ia);
  issue_entry(b, ib);
  post_result(ib, xorshift32(), 1'b0, E_NONE);
  for (i = 0; i < 6; i++) begin
    @(negedge clk);
    check_bit(comm_valid, 1'b0, "comm_valid_o with same rd as head");
  end
  post_result(ia, xorshift32(), 1'b0, E_NONE);
  exp_q.push_back(ia);
  exp_q.push_back(ib);
  drain_commits();
endtask

task automatic operand_forwarding();
  rob_entry_t c, d;
  rob_idx_t   ic, id;
  xlen_t      vc, vd;
  c = make_entry(1'b1, 5'd11, 1'b1, 1'b0);
  d = make_entry(1'b1, 5'd12, 1'b1, 1'b0);
  issue_entry(c, ic);
  issue_entry(d, id);
  @(posedge clk);
  rs1_idx <= ic;
  rs2_idx <= id;
  @(negedge clk);
  check_fwd(fwd_rs1, expected_fwd(1'b1, 1'b0, '0), "fwd_rs1_o before result");
  check_fwd(fwd_rs2, expected_fwd(1'b1, 1'b0, '0), "fwd_rs2_o before result");
  vc = xorshift32();
  post_result(ic, vc, 1'b0, E_NONE);
  @(negedge clk);
  check_fwd(fwd_rs1, expected_fwd(1'b1, 1'b1, vc), "fwd_rs1_o after result");
  check_fwd(fwd_rs2, expected_fwd(1'b1, 1'b0, '0), "fwd_rs2_o still pending");
  vd = xorshift32();
  post_result(id, vd, 1'b0, E_NONE);
  @(negedge clk);
  check_fwd(fwd_rs2, expected_fwd(1'b1, 1'b1, vd), "fwd_rs2_o after result");
  exp_q.push_back(ic);
  exp_q.push_back(id);
  drain_commits();
  @(negedge clk);
  check_bit(fwd_rs1.valid, 1'b0, "fwd_rs1_o valid after commit");
endtask

task automatic store_clearance();
  rob_entry_t   m, s;
  rob_idx_t     i_mem, i_st;
  except_code_t code;
  int           pass, i;
  for (pass = 0; pass < 2; pass++) begin
    // Second round resolves as a misprediction
    code = (pass == 0) ? E_NONE : E_MISPREDICTION;
    m = make_entry(1'b1, 5'd10, 1'b1, 1'b1);
    s = make_entry(1'b0, 5'd0, 1'b1, 1'b0);
    issue_entry(m, i_mem);
    issue_entry(s, i_st);
    @(posedge clk);
    sb_idx <= i_st;
    for (i = 0; i < 4; i++) begin
      @(negedge clk);
      check_bit(sb_clear, 1'b0, "sb_mem_clear_o before branch result");
    end
    post_result(i_mem, xorshift32(), 1'b0, code);
    for (i = 0; i < 4; i++) begin
      @(negedge clk);
      check_bit(sb_clear, code == E_NONE, "sb_mem_clear_o after branch result");
    end
    post_result(i_st, xorshift32(), 1'b0, E_NONE);
    exp_q.push_back(i_mem);
    exp_q.push_back(i_st);
    drain_commits();
  end
endtask

task automatic full_buffer_stall();
  rob_entry_t e;
  rob_idx_t   idx;
  int         i;
  // Commit side stalled while the buffer fills
  for (i = 0; i < ROB_DEPTH; i++) begin
    e           = make_entry(1'b1, reg_idx_t'(i), 1'b1, 1'b0);
    e.res_ready = 1'b1;
    e.res_value = xorshift32();
    issue_entry(e, idx);
    exp_q.push_back(idx);
    @(negedge clk);
    check_bit(comm_valid, 1'b1, "comm_valid_o under back-pressure");
    check_idx(comm_idx, exp_q[0], "held comm_idx_o");
    check_entry(comm_data, exp_mem[exp_q[0]], "held comm_data_o");
  end
  check_bit(issue_ready, 1'b0, "issue_ready_o with full buffer");
  drain_commits();
  @(negedge clk);
  check_bit(comm_valid, 1'b0, "comm_valid_o after drain");
  check_bit(issue_ready, 1'b1, "issue_ready_o after drain");
endtask

task automatic flush_restart();
  rob_entry_t e;
  rob_idx_t   idx;
  int         i;
  for (i = 0; i < 3; i++) begin
    e           = make_entry(1'b1, reg_idx_t'(i + 20), 1'b1, 1'b0);
    e.res_ready = 1'b1;
    e.res_value = xorshift32();
    issue_entry(e, idx);
  end
  @(negedge clk);
  check_bit(comm_valid, 1'b1, "comm_valid_o before flush");
  @(posedge clk);
  flush <= 1'b1;
  @(posedge clk);
  flush <= 1'b0;
  exp_tail = '0;
  @(negedge clk);
  check_bit(comm_valid, 1'b0, "comm_valid_o after flush");
  check_bit(issue_ready, 1'b1, "issue_ready_o after flush");
  check_idx(issue_tail, '0, "issue_tail_idx_o after flush");
  check_bit(sb_clear, 1'b0, "sb_mem_clear_o after flush");
  // Buffer restarts from slot 0
  e           = make_entry(1'b1, 5'd30, 1'b1, 1'b0);
  e.res_ready = 1'b1;
  e.res_value = xorshift32();
  issue_entry(e, idx);
  exp_q.push_back(idx);
  drain_commits();
endtask

/* bench/tb_rob.sv */
/* Directed testbench for the reorder buffer top level.
   Plays issue, CDB, commit and store-buffer sides against a small model. */
`timescale 1ns/100ps

module tb_rob import rob_pkg::*; ();

  // Cycles any single wait may take
  localparam int TIMEOUT_CYC = 200;

  // ------------------------------------------------------------------
  // DUT signals
  // ------------------------------------------------------------------
  logic       clk = 1'b0;
  logic       rst_n;
  logic       flush;
  logic       issue_valid;
  logic       issue_ready;
  rob_entry_t issue_data;
  rob_idx_t   issue_tail;
  rob_idx_t   rs1_idx;
  rob_idx_t   rs2_idx;
  rob_fwd_t   fwd_rs1;
  rob_fwd_t   fwd_rs2;
  logic       cdb_valid;
  cdb_data_t  cdb_data;
  logic       comm_valid;
  logic       comm_ready;
  rob_entry_t comm_data;
  rob_idx_t   comm_idx;
  rob_idx_t   sb_idx;
  logic       sb_clear;

  // Model of the expected slot contents, commit order and tail
  rob_entry_t  exp_mem [ROB_DEPTH];
  rob_idx_t    exp_q [$];
  rob_idx_t    exp_tail;
  logic [31:0] rng_state;

  `include "tb_rob_tasks.svh"

  // 10 ns clock
  always #5ns clk = ~clk;

  rob_top u_dut (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .flush_i         (flush),
    .issue_valid_i   (issue_valid),
    .issue_ready_o   (issue_ready),
    .issue_data_i    (issue_data),
    .issue_tail_idx_o(issue_tail),
    .issue_rs1_idx_i (rs1_idx),
    .issue_rs2_idx_i (rs2_idx),
    .fwd_rs1_o       (fwd_rs1),
    .fwd_rs2_o       (fwd_rs2),
    .cdb_valid_i     (cdb_valid),
    .cdb_data_i      (cdb_data),
    .comm_valid_o    (comm_valid),
    .comm_ready_i    (comm_ready),
    .comm_data_o     (comm_data),
    .comm_idx_o      (comm_idx),
    .sb_mem_idx_i    (sb_idx),
    .sb_mem_clear_o  (sb_clear)
  );

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------
  initial begin : p_main
    rng_state   = 32'hcd074635;
    exp_tail    = '0;
    rst_n       = 1'b0;
    flush       = 1'b0;
    issue_valid = 1'b0;
    issue_data  = '0;
    rs1_idx     = '0;
    rs2_idx     = '0;
    cdb_valid   = 1'b0;
    cdb_data    = '0;
    comm_ready  = 1'b0;
    sb_idx      = '0;

    // Reset held for 16 cycles
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    in_order_flow();
    lookahead_commit();
    operand_forwarding();
    store_clearance();
    full_buffer_stall();
    flush_restart();

    repeat (2) @(posedge clk);
    $display("TB PASSED");
    $finish;
  end

endmodule

/* hw/rob_top.sv */
/* Reorder buffer top level for the out-of-order execution pipeline.
   Ties the entry store, clear tracker and commit selector together. */
`timescale 1ns/100ps

module rob_top import rob_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       flush_i,
  // Issue
  input  logic       issue_valid_i,
  output logic       issue_ready_o,
  input  rob_entry_t issue_data_i,
  output rob_idx_t   issue_tail_idx_o,
  input  rob_idx_t   issue_rs1_idx_i,
  input  rob_idx_t   issue_rs2_idx_i,
  output rob_fwd_t   fwd_rs1_o,
  output rob_fwd_t   fwd_rs2_o,
  // Common data bus
  input  logic       cdb_valid_i,
  input  cdb_data_t  cdb_data_i,
  // Commit
  output logic       comm_valid_o,
  input  logic       comm_ready_i,
  output rob_entry_t comm_data_o,
  output rob_idx_t   comm_idx_o,
  // Store buffer
  input  rob_idx_t   sb_mem_idx_i,
  output logic       sb_mem_clear_o
);

  // Store to tracker and selector
  logic [ROB_DEPTH-1:0] entry_valid;
  logic                 push;
  rob_entry_t           clear_entry, head_entry, look_entry;
  // Tracker to selector
  rob_idx_t             clear_idx;
  logic [ROB_DEPTH-1:0] clear_marks;
  // Selector back to store
  rob_idx_t             head_idx, look_idx, pop_idx;
  logic                 pop;

  rob_entry_store u_store (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .issue_valid_i   (issue_valid_i),
    .issue_data_i    (issue_data_i),
    .issue_ready_o   (issue_ready_o),
    .issue_tail_idx_o(issue_tail_idx_o),
    .cdb_valid_i     (cdb_valid_i),
    .cdb_data_i      (cdb_data_i),
    .pop_i           (pop),
    .pop_idx_i       (pop_idx),
    .rd_a_idx_i      (clear_idx),
    .rd_b_idx_i      (head_idx),
    .rd_c_idx_i      (look_idx),
    .rd_a_o          (clear_entry),
    .rd_b_o          (head_entry),
    .rd_c_o          (look_entry),
    .valid_o         (entry_valid),
    .push_o          (push),
    .rs1_idx_i       (issue_rs1_idx_i),
    .rs2_idx_i       (issue_rs2_idx_i),
    .fwd_rs1_o       (fwd_rs1_o),
    .fwd_rs2_o       (fwd_rs2_o)
  );

  // Pushed entry sits at the current tail
  rob_clear_tracker u_clear (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .push_i        (push),
    .push_idx_i    (issue_tail_idx_o),
    .valid_i       (entry_valid),
    .clear_entry_i (clear_entry),
    .cdb_valid_i   (cdb_valid_i),
    .cdb_data_i    (cdb_data_i),
    .clear_idx_o   (clear_idx),
    .clear_marks_o (clear_marks),
    .sb_mem_idx_i  (sb_mem_idx_i),
    .sb_mem_clear_o(sb_mem_clear_o)
  );

  rob_commit_select u_commit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .valid_i      (entry_valid),
    .clear_marks_i(clear_marks),
    .head_entry_i (head_entry),
    .look_entry_i (look_entry),
    .head_idx_o   (head_idx),
    .look_idx_o   (look_idx),
    .comm_valid_o (comm_valid_o),
    .comm_ready_i (comm_ready_i),
    .comm_data_o  (comm_data_o),
    .comm_idx_o   (comm_idx_o),
    .pop_o        (pop),
    .pop_idx_o    (pop_idx)
  );

endmodule

/* hw/rob_commit_select.sv */
/* Picks the committing entry: the head in order, else the lookahead entry.
   Drives the commit port and tells the entry store what to pop. */
`timescale 1ns/100ps

module rob_commit_select import rob_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic [ROB_DEPTH-1:0] valid_i,
  input  logic [ROB_DEPTH-1:0] clear_marks_i,
  // Entries under the head and lookahead pointers
  input  rob_entry_t           head_entry_i,
  input  rob_entry_t           look_entry_i,
  output rob_idx_t             head_idx_o,
  output rob_idx_t             look_idx_o,
  // Commit port
  output logic                 comm_valid_o,
  input  logic                 comm_ready_i,
  output rob_entry_t           comm_data_o,
  output rob_idx_t             comm_idx_o,
  // Pop towards the entry store
  output logic                 pop_o,
  output rob_idx_t             pop_idx_o
);

  rob_idx_t head_q, look_idx;
  logic     head_ok, look_ok, waw;
  logic     use_head, look_hold_q;

  // ------------------------------------------------------------------
  // Commit conditions
  // ------------------------------------------------------------------
  // In order: head present with its result
  assign head_ok = valid_i[head_q] & head_entry_i.res_ready;

  // Both write the same destination
  assign waw = head_entry_i.rd_upd & look_entry_i.rd_upd &
               (head_entry_i.rd_idx == look_entry_i.rd_idx);

  // Lookahead only when nothing older can redirect
  assign look_ok = valid_i[look_idx] & ~look_entry_i.order_crit &
                   look_entry_i.res_ready & ~look_entry_i.except_raised &
                   (look_entry_i.except_code != E_MISPREDICTION) &
                   clear_marks_i[look_idx] & ~waw;

  // Offered lookahead stays selected until taken
  assign use_head = head_ok & ~look_hold_q;

  assign comm_valid_o = use_head | look_ok;
  assign comm_idx_o   = use_head ? head_q : look_idx;
  assign comm_data_o  = use_head ? head_entry_i : look_entry_i;

  assign pop_o     = comm_valid_o & comm_ready_i;
  assign pop_idx_o = comm_idx_o;

  // ------------------------------------------------------------------
  // Pointers
  // ------------------------------------------------------------------
  // Lookahead moves on every pop, in order or not
  modn_counter #(
    .N   (ROB_DEPTH),
    .INIT(1)
  ) u_look_cnt (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .en_i   (pop_o),
    .clr_i  (flush_i),
    .count_o(look_idx)
  );

  // Slots between head and lookahead are already gone
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_head
    if (!rst_ni) begin
      head_q <= '0;
    end else if (flush_i) begin
      head_q <= '0;
    end else if (pop_o && use_head) begin
      head_q <= look_idx;
    end
  end

  // Remember a lookahead offer under back-pressure
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_look_hold
    if (!rst_ni) begin
      look_hold_q <= 1'b0;
    end else if (flush_i || pop_o) begin
      look_hold_q <= 1'b0;
    end else if (comm_valid_o && !use_head) begin
      look_hold_q <= 1'b1;
    end
  end

  assign head_idx_o = head_q;
  assign look_idx_o = look_idx;

  // Stalled commit keeps its offer unchanged
  a_comm_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    comm_valid_o && !comm_ready_i && !flush_i |=>
      comm_valid_o && $stable(comm_idx_o) && $stable(comm_data_o));

endmodule

/* hw/rob_clear_tracker.sv */
/* Walks the ROB in order and marks entries past every possible redirect.
   The marks answer store-buffer requests to access memory early. */
`timescale 1ns/100ps

module rob_clear_tracker import rob_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  // Allocation from the entry store
  input  logic                 push_i,
  input  rob_idx_t             push_idx_i,
  input  logic [ROB_DEPTH-1:0] valid_i,
  // Entry under the clear pointer
  input  rob_entry_t           clear_entry_i,
  // Common data bus
  input  logic                 cdb_valid_i,
  input  cdb_data_t            cdb_data_i,
  output rob_idx_t             clear_idx_o,
  output logic [ROB_DEPTH-1:0] clear_marks_o,
  // Store buffer query
  input  rob_idx_t             sb_mem_idx_i,
  output logic                 sb_mem_clear_o
);

  rob_idx_t             clear_idx;
  logic [ROB_DEPTH-1:0] marks_q;
  logic                 entry_ok, cdb_ok, clear_now;

  // ------------------------------------------------------------------
  // Clear condition
  // ------------------------------------------------------------------
  // Stored result rules out a redirect
  assign entry_ok = clear_entry_i.res_ready & ~clear_entry_i.except_raised &
                    (clear_entry_i.except_code != E_MISPREDICTION);

  // Same check on a result arriving right now
  assign cdb_ok = cdb_valid_i & (cdb_data_i.rob_idx == clear_idx) &
                  ~cdb_data_i.except_raised &
                  (cdb_data_i.except_code != E_MISPREDICTION);

  // Non-critical entries pass without waiting
  assign clear_now = valid_i[clear_idx] & (~clear_entry_i.mem_crit | entry_ok | cdb_ok);

  // One step per cycle at most
  modn_counter #(
    .N   (ROB_DEPTH),
    .INIT(0)
  ) u_clear_cnt (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .en_i   (clear_now),
    .clr_i  (flush_i),
    .count_o(clear_idx)
  );

  // Clear marks are dropped again when a slot is reallocated
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_marks
    if (!rst_ni) begin
      marks_q <= '0;
    end else if (flush_i) begin
      marks_q <= '0;
    end else begin
      if (clear_now) begin
        marks_q[clear_idx] <= 1'b1;
      end
      // Pushed slot is free, so never the one being marked
      if (push_i) begin
        marks_q[push_idx_i] <= 1'b0;
      end
    end
  end

  // ------------------------------------------------------------------
  // Outputs
  // ------------------------------------------------------------------
  assign clear_idx_o   = clear_idx;
  assign clear_marks_o = marks_q;

  // Entry at the pointer has every older entry behind it cleared
  assign sb_mem_clear_o = valid_i[sb_mem_idx_i] &
                          (marks_q[sb_mem_idx_i] | (clear_idx == sb_mem_idx_i));

endmodule

/* hw/rob_entry_store.sv */
/* ROB entry array with tail allocation, CDB write-back and commit pop.
   Offers three combinational entry reads and two forwarding reads. */
`timescale 1ns/100ps

module rob_entry_store import rob_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  // Issue side
  input  logic                 issue_valid_i,
  input  rob_entry_t           issue_data_i,
  output logic                 issue_ready_o,
  output rob_idx_t             issue_tail_idx_o,
  // Common data bus
  input  logic                 cdb_valid_i,
  input  cdb_data_t            cdb_data_i,
  // Pop from the commit selector
  input  logic                 pop_i,
  input  rob_idx_t             pop_idx_i,
  // Entry read ports
  input  rob_idx_t             rd_a_idx_i,
  input  rob_idx_t             rd_b_idx_i,
  input  rob_idx_t             rd_c_idx_i,
  output rob_entry_t           rd_a_o,
  output rob_entry_t           rd_b_o,
  output rob_entry_t           rd_c_o,
  output logic [ROB_DEPTH-1:0] valid_o,
  output logic                 push_o,
  // Operand forwarding
  input  rob_idx_t             rs1_idx_i,
  input  rob_idx_t             rs2_idx_i,
  output rob_fwd_t             fwd_rs1_o,
  output rob_fwd_t             fwd_rs2_o
);

  // Storage
  rob_entry_t           data_q [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] valid_q;

  // Tail pointer and push strobe
  rob_idx_t tail_idx;
  logic     push;

  // ------------------------------------------------------------------
  // Allocation
  // ------------------------------------------------------------------
  // Tail slot must be free to accept
  assign issue_ready_o = ~valid_q[tail_idx];
  assign push          = issue_valid_i & issue_ready_o;

  modn_counter #(
    .N   (ROB_DEPTH),
    .INIT(0)
  ) u_tail_cnt (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .en_i   (push),
    .clr_i  (flush_i),
    .count_o(tail_idx)
  );

  // Valid bits, flush empties the whole buffer
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else begin
      // Push and pop never share an index
      if (push) begin
        valid_q[tail_idx] <= 1'b1;
      end
      if (pop_i) begin
        valid_q[pop_idx_i] <= 1'b0;
      end
    end
  end

  // Entry payload, push first, then pop, then CDB
  always_ff @(posedge clk_i) begin : p_data
    for (int unsigned i = 0; i < ROB_DEPTH; i++) begin
      if (push && tail_idx == rob_idx_t'(i)) begin
        data_q[i] <= issue_data_i;
      end else if (pop_i && pop_idx_i == rob_idx_t'(i)) begin
        // Leaving entry keeps its stale payload
        data_q[i] <= data_q[i];
      end else if (cdb_valid_i && cdb_data_i.rob_idx == rob_idx_t'(i)) begin
        data_q[i].res_ready     <= 1'b1;
        data_q[i].res_value     <= cdb_data_i.res_value;
        data_q[i].except_raised <= cdb_data_i.except_raised;
        data_q[i].except_code   <= cdb_data_i.except_code;
      end
    end
  end

  // ------------------------------------------------------------------
  // Read side
  // ------------------------------------------------------------------
  assign issue_tail_idx_o = tail_idx;
  assign push_o           = push;
  assign valid_o          = valid_q;

  // Clear pointer, head and lookahead reads
  assign rd_a_o = data_q[rd_a_idx_i];
  assign rd_b_o = data_q[rd_b_idx_i];
  assign rd_c_o = data_q[rd_c_idx_i];

  // Forwarding answers for the two source operands
  always_comb begin : p_fwd
    fwd_rs1_o.valid = valid_q[rs1_idx_i];
    fwd_rs1_o.ready = data_q[rs1_idx_i].res_ready;
    fwd_rs1_o.value = data_q[rs1_idx_i].res_value;
    fwd_rs2_o.valid = valid_q[rs2_idx_i];
    fwd_rs2_o.ready = data_q[rs2_idx_i].res_ready;
    fwd_rs2_o.value = data_q[rs2_idx_i].res_value;
  end

  // ------------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------------
  // Results only go to allocated entries
  a_cdb_target : assert property (@(posedge clk_i) disable iff (!rst_ni)
    cdb_valid_i |-> valid_q[cdb_data_i.rob_idx]);

  // Commit never frees the slot being allocated
  a_push_pop : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push && pop_i |-> tail_idx != pop_idx_i);

endmodule

/* hw/modn_counter.sv */
/* Modulo-N up counter with enable, synchronous clear and a start value.
   Used for the tail, clear and lookahead pointers of the ROB. */
`timescale 1ns/100ps

module modn_counter #(
  parameter int unsigned N    = 8,
  parameter int unsigned INIT = 0
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 en_i,
  input  logic                 clr_i,
  output logic [$clog2(N)-1:0] count_o
);

  // Current count
  logic [$clog2(N)-1:0] count_q;

  // ------------------------------------------------------------------
  // Count register
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_count
    if (!rst_ni) begin
      count_q <= INIT[$clog2(N)-1:0];
    end else if (clr_i) begin
      // Clear wins over enable
      count_q <= INIT[$clog2(N)-1:0];
    end else if (en_i) begin
      // Wrap at N, which need not be a power of two
      if (count_q == N - 1) begin
        count_q <= '0;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  assign count_o = count_q;

  // Start value must lie inside the range
  initial begin : p_param_check
    assert (INIT < N)
    else $error("modn_counter: INIT outside 0..N-1");
  end

endmodule

/* hw/rob_pkg.sv */
/* Shared widths, types and exception codes of the reorder buffer.
   Imported by every ROB module and by the testbench. */
package rob_pkg;

  // ------------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------------
  // Data path width
  localparam int XLEN = 32;
  // Number of ROB entries, power of two
  localparam int ROB_DEPTH = 8;
  localparam int ROB_IDX_W = $clog2(ROB_DEPTH);
  // Architectural register index
  localparam int REG_IDX_W = 5;

  // Plain vector types
  typedef logic [XLEN-1:0]      xlen_t;
  typedef logic [ROB_IDX_W-1:0] rob_idx_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // Exception codes, loosely following mcause
  typedef enum logic [3:0] {
    E_NONE          = 4'h0,
    E_ILLEGAL       = 4'h2,
    E_LOAD_FAULT    = 4'h5,
    E_STORE_FAULT   = 4'h7,
    E_ECALL         = 4'hb,
    // Implementation specific, branch went the wrong way
    E_MISPREDICTION = 4'hf
  } except_code_t;

  // ------------------------------------------------------------------
  // Structures
  // ------------------------------------------------------------------
  // One ROB entry
  typedef struct packed {
    logic         rd_upd;
    reg_idx_t     rd_idx;
    xlen_t        res_value;
    logic         res_ready;
    logic         except_raised;
    except_code_t except_code;
    // Never commits ahead of the head
    logic         order_crit;
    // May redirect control flow before a later memory access
    logic         mem_crit;
  } rob_entry_t;

  // Result broadcast on the common data bus
  typedef struct packed {
    rob_idx_t     rob_idx;
    xlen_t        res_value;
    logic         except_raised;
    except_code_t except_code;
  } cdb_data_t;

  // Operand forwarding answer for one source register
  typedef struct packed {
    logic  valid;
    logic  ready;
    xlen_t value;
  } rob_fwd_t;

endpackage
